/* hdl/join_cfg.svh */
// ----------------------------------------
// sizes shared by the header/payload joiner.
// include wherever a width is needed.
// ----------------------------------------

`ifndef JOIN_CFG_SVH
`define JOIN_CFG_SVH

// bytes per stream word.
`define JOIN_DATA_BYTES 8

// data bus width in bits.
`define JOIN_DATA_BITS (`JOIN_DATA_BYTES * 8)

// metadata field widths.
`define JOIN_TID_BITS   4
`define JOIN_TDEST_BITS 4
`define JOIN_TUSER_BITS 8

// holds a byte count from 0 up to a full word.
`define JOIN_COUNT_BITS 4

`endif

/* hdl/join_pkg.sv */
// ----------------------------------------
// stream word and metadata types for the joiner.
// ----------------------------------------

`include "join_cfg.svh"

package join_pkg;

   // number of valid bytes in one word.
   typedef logic [`JOIN_COUNT_BITS-1:0] count_t;

   // ----------------------------------------
   // payload stream word
   // ----------------------------------------
   typedef struct packed {
      logic [`JOIN_DATA_BITS-1:0]  data;
      logic [`JOIN_DATA_BYTES-1:0] keep;
      logic                        last;
   } beat_t;

   // ----------------------------------------
   // per-packet metadata
   // ----------------------------------------
   typedef struct packed {
      logic [`JOIN_TID_BITS-1:0]   tid;
      logic [`JOIN_TDEST_BITS-1:0] tdest;
      logic [`JOIN_TUSER_BITS-1:0] tuser;
   } meta_t;

   // header and output stream word.
   // metadata rides along with every word.
   typedef struct packed {
      beat_t beat;
      meta_t meta;
   } hdr_beat_t;

endpackage

/* hdl/stream_reg.sv */
// ----------------------------------------
// one-entry valid/ready register stage.
// payload type is set per instance.
// ----------------------------------------

`timescale 1ns/100ps

module stream_reg #(
   parameter type beat_type = logic [7:0]
) (
   input  logic     clk,
   input  logic     resetn,

   input  beat_type in_beat,
   input  logic     in_valid,
   output logic     in_ready,

   output beat_type out_beat,
   output logic     out_valid,
   input  logic     out_ready
);

   // ready is held off until the cycle after reset.
   logic ready_en;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ready_en <= 1'b0;
      end else begin
         ready_en <= 1'b1;
      end
   end

   // accept when empty, or when the held word leaves this cycle.
   assign in_ready = ready_en && (!out_valid || out_ready);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   // payload only loads on a transfer.
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_beat <= in_beat;
      end
   end

endmodule

/* hdl/byte_merge.sv */
// ----------------------------------------
// residue register and byte merge path.
// packs header tail bytes and payload words into full words.
// ----------------------------------------

`timescale 1ns/100ps

`include "join_cfg.svh"

module byte_merge (
   input  logic            clk,
   input  logic            resetn,

   input  join_pkg::beat_t hdr_beat,
   input  join_pkg::beat_t pyld_beat,

   input  logic            hdr_take,
   input  logic            pyld_take,
   input  logic            flush_take,

   output join_pkg::beat_t merged,
   output logic            flush_pending
);

   import join_pkg::*;

   localparam int NB = `JOIN_DATA_BYTES;

   logic [NB-1:0][7:0]          res_data;
   count_t                      res_count;
   logic                        spill;

   count_t                      hdr_count;
   count_t                      pyld_count;
   logic [`JOIN_COUNT_BITS:0]   total;
   logic                        overflow;

   logic [NB-1:0][7:0]          pyld_bytes;
   logic [NB-1:0][7:0]          shifted;
   logic [NB-1:0][7:0]          next_res;
   logic [NB-1:0][7:0]          join_data;
   logic [NB-1:0]               join_keep;
   logic [NB-1:0]               res_keep;

   // keep is contiguous from byte 0, so the top set bit gives the count.
   function automatic count_t keep_count(input logic [NB-1:0] keep);
      count_t cnt;
      cnt = '0;
      for (int i = 0; i < NB; i++) begin
         if (keep[i]) cnt = count_t'(i + 1);
      end
      return cnt;
   endfunction

   // ----------------------------------------
   // merge datapath
   // ----------------------------------------
   always_comb begin
      hdr_count  = keep_count(hdr_beat.keep);
      pyld_count = keep_count(pyld_beat.keep);
      total      = {1'b0, res_count} + {1'b0, pyld_count};
      overflow   = (total > NB);

      pyld_bytes = pyld_beat.data;
      // payload moves up past the residue.
      shifted    = pyld_bytes << (8 * res_count);
      // bytes that did not fit drop down to the bottom.
      next_res   = pyld_bytes >> (8 * (NB - res_count));

      for (int i = 0; i < NB; i++) begin
         join_data[i] = (i < res_count) ? res_data[i] : shifted[i];
         join_keep[i] = (i < total);
         res_keep[i]  = (i < res_count);
      end

      // a pending spill word takes priority over the merge.
      merged.data   = spill ? res_data : join_data;
      merged.keep   = spill ? res_keep : join_keep;
      merged.last   = spill | (pyld_beat.last & ~overflow);
      flush_pending = pyld_beat.last & overflow;
   end

   // ----------------------------------------
   // residue state
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (!resetn) begin
         res_count <= '0;
         spill     <= 1'b0;
      end else if (hdr_take) begin
         res_count <= hdr_count;
      end else if (pyld_take) begin
         res_count <= overflow ? count_t'(total - NB) : '0;
         spill     <= flush_pending;
      end else if (flush_take) begin
         res_count <= '0;
         spill     <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_take) begin
         res_data <= hdr_beat.data;
      end else if (pyld_take) begin
         res_data <= next_res;
      end
   end

endmodule

/* hdl/join_fsm.sv */
// ----------------------------------------
// packet sequencer for the joiner.
// steps header, payload, flush and drop phases.
// ----------------------------------------

`timescale 1ns/100ps

module join_fsm (
   input  logic                clk,
   input  logic                resetn,

   input  join_pkg::hdr_beat_t hdr_beat,
   input  logic                hdr_valid,
   output logic                hdr_ready,

   input  logic                pyld_valid,
   input  logic                pyld_last,
   output logic                pyld_ready,

   input  join_pkg::beat_t     merged,
   input  logic                flush_pending,

   output logic                hdr_take,
   output logic                pyld_take,
   output logic                flush_take,

   output join_pkg::hdr_beat_t out_beat,
   output logic                out_valid,
   input  logic                out_ready
);

   import join_pkg::*;

   typedef enum logic [1:0] {
      HEADER,
      PAYLOAD,
      FLUSH,
      DROP
   } state_t;

   state_t state, state_nxt;

   logic  hdr_first;
   logic  is_drop;
   meta_t meta_q;

   // one-word header with no valid bytes.
   assign is_drop = hdr_first && hdr_beat.beat.last && (hdr_beat.beat.keep == '0);

   // ----------------------------------------
   // next state and handshakes
   // ----------------------------------------
   always_comb begin
      state_nxt  = state;
      hdr_ready  = 1'b0;
      pyld_ready = 1'b0;
      out_valid  = 1'b0;
      hdr_take   = 1'b0;
      pyld_take  = 1'b0;
      flush_take = 1'b0;

      case (state)
         HEADER: begin
            if (hdr_beat.beat.last) begin
               // tail word goes into the residue, not out.
               hdr_ready = 1'b1;
               if (hdr_valid) begin
                  if (is_drop) begin
                     state_nxt = DROP;
                  end else begin
                     hdr_take  = 1'b1;
                     state_nxt = PAYLOAD;
                  end
               end
            end else begin
               out_valid = hdr_valid;
               hdr_ready = out_ready;
            end
         end
         PAYLOAD: begin
            out_valid  = pyld_valid;
            pyld_ready = out_ready;
            pyld_take  = pyld_valid && out_ready;
            if (pyld_take && pyld_last) begin
               state_nxt = flush_pending ? FLUSH : HEADER;
            end
         end
         FLUSH: begin
            out_valid  = 1'b1;
            flush_take = out_ready;
            if (out_ready) state_nxt = HEADER;
         end
         default: begin
            // discard the payload, nothing goes out.
            pyld_ready = 1'b1;
            if (pyld_valid && pyld_last) state_nxt = HEADER;
         end
      endcase
   end

   // header words pass through as is, the rest come from the merge.
   assign out_beat.beat = (state == HEADER) ? hdr_beat.beat : merged;
   assign out_beat.meta = (state == HEADER && hdr_first) ? hdr_beat.meta : meta_q;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state     <= HEADER;
         hdr_first <= 1'b1;
      end else begin
         state <= state_nxt;
         if (hdr_valid && hdr_ready) hdr_first <= hdr_beat.beat.last;
      end
   end

   // metadata comes from the first header word only.
   always_ff @(posedge clk) begin
      if (hdr_valid && hdr_ready && hdr_first) begin
         meta_q <= hdr_beat.meta;
      end
   end

endmodule

/* hdl/pkt_join_top.sv */
// ----------------------------------------
// header/payload joiner top level.
// registers both inputs and the joined output.
// ----------------------------------------

`timescale 1ns/100ps

module pkt_join_top (
   input  logic                clk,
   input  logic                resetn,

   input  join_pkg::hdr_beat_t hdr_in,
   input  logic                hdr_valid,
   output logic                hdr_ready,

   input  join_pkg::beat_t     pyld_in,
   input  logic                pyld_valid,
   output logic                pyld_ready,

   output join_pkg::hdr_beat_t out,
   output logic                out_valid,
   input  logic                out_ready
);

   import join_pkg::*;

   hdr_beat_t hdr_q;
   logic      hdr_q_valid;
   logic      hdr_q_ready;

   beat_t     pyld_q;
   logic      pyld_q_valid;
   logic      pyld_q_ready;

   beat_t     merged;
   logic      flush_pending;
   logic      hdr_take;
   logic      pyld_take;
   logic      flush_take;

   hdr_beat_t join_beat;
   logic      join_valid;
   logic      join_ready;

   // ----------------------------------------
   // input stages
   // ----------------------------------------
   stream_reg #(.beat_type(hdr_beat_t)) hdr_reg (
      .clk       (clk),
      .resetn    (resetn),
      .in_beat   (hdr_in),
      .in_valid  (hdr_valid),
      .in_ready  (hdr_ready),
      .out_beat  (hdr_q),
      .out_valid (hdr_q_valid),
      .out_ready (hdr_q_ready)
   );

   stream_reg #(.beat_type(beat_t)) pyld_reg (
      .clk       (clk),
      .resetn    (resetn),
      .in_beat   (pyld_in),
      .in_valid  (pyld_valid),
      .in_ready  (pyld_ready),
      .out_beat  (pyld_q),
      .out_valid (pyld_q_valid),
      .out_ready (pyld_q_ready)
   );

   // ----------------------------------------
   // sequencing and merge
   // ----------------------------------------
   join_fsm fsm (
      .clk           (clk),
      .resetn        (resetn),
      .hdr_beat      (hdr_q),
      .hdr_valid     (hdr_q_valid),
      .hdr_ready     (hdr_q_ready),
      .pyld_valid    (pyld_q_valid),
      .pyld_last     (pyld_q.last),
      .pyld_ready    (pyld_q_ready),
      .merged        (merged),
      .flush_pending (flush_pending),
      .hdr_take      (hdr_take),
      .pyld_take     (pyld_take),
      .flush_take    (flush_take),
      .out_beat      (join_beat),
      .out_valid     (join_valid),
      .out_ready     (join_ready)
   );

   byte_merge merge (
      .clk           (clk),
      .resetn        (resetn),
      .hdr_beat      (hdr_q.beat),
      .pyld_beat     (pyld_q),
      .hdr_take      (hdr_take),
      .pyld_take     (pyld_take),
      .flush_take    (flush_take),
      .merged        (merged),
      .flush_pending (flush_pending)
   );

   // output stage.
   stream_reg #(.beat_type(hdr_beat_t)) out_reg (
      .clk       (clk),
      .resetn    (resetn),
      .in_beat   (join_beat),
      .in_valid  (join_valid),
      .in_ready  (join_ready),
      .out_beat  (out),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

/* tests/pkt_join_sva.sv */
// ----------------------------------------
// handshake and output format checks, bound into the joiner top level.
// ----------------------------------------

`timescale 1ns/100ps

`include "join_cfg.svh"

module pkt_join_sva (
   input logic                clk,
   input logic                resetn,
   input logic                hdr_ready,
   input logic                pyld_ready,
   input join_pkg::hdr_beat_t out,
   input logic                out_valid,
   input logic                out_ready
);

   localparam logic [`JOIN_DATA_BYTES-1:0] KEEP_ONE = 1;

   // number of failed properties.
   int   violations = 0;
   logic reset_seen = 1'b0;

   always @(posedge clk) begin
      if (!resetn) reset_seen <= 1'b1;
   end

   // no handshake is offered in reset or in the cycle after it.
   quiet_in_reset: assert property (@(posedge clk)
      ((!resetn && reset_seen) || $rose(resetn)) |-> !out_valid && !hdr_ready && !pyld_ready)
   else begin
      $error("a valid or ready signal was high during reset");
      violations++;
   end

   out_held: assert property (@(posedge clk) disable iff (!resetn)
      out_valid && !out_ready |=> out_valid && $stable(out))
   else begin
      $error("output word changed while stalled");
      violations++;
   end

   // keep runs from byte 0 and is never empty.
   keep_format: assert property (@(posedge clk) disable iff (!resetn)
      out_valid |-> (out.beat.keep != '0) && ((out.beat.keep & (out.beat.keep + KEEP_ONE)) == '0))
   else begin
      $error("output keep is empty or not contiguous");
      violations++;
   end

endmodule

bind pkt_join_top pkt_join_sva assertions_i (
   .clk        (clk),
   .resetn     (resetn),
   .hdr_ready  (hdr_ready),
   .pyld_ready (pyld_ready),
   .out        (out),
   .out_valid  (out_valid),
   .out_ready  (out_ready)
);

/* tests/pkt_join_tb.sv */
// ----------------------------------------
// testbench for the header/payload joiner.
// random packets go in, a reference packer predicts every output word.
// ----------------------------------------

`timescale 1ns/100ps

`include "join_cfg.svh"

module pkt_join_tb;

   import join_pkg::*;

   localparam int NB        = `JOIN_DATA_BYTES;
   localparam int TIMEOUT   = 2000;
   localparam int NUM_RAND  = 60;
   localparam int READY_LEN = 1024;

   typedef logic [7:0] byte_q_t[$];
   typedef hdr_beat_t  word_q_t[$];

   logic      clk;
   logic      resetn;
   hdr_beat_t hdr_in;
   logic      hdr_valid;
   logic      hdr_ready;
   beat_t     pyld_in;
   logic      pyld_valid;
   logic      pyld_ready;
   hdr_beat_t out;
   logic      out_valid;
   logic      out_ready;

   integer    seed;
   hdr_beat_t hdr_stim_q[$];
   int        hdr_gap_q[$];
   beat_t     pyld_stim_q[$];
   int        pyld_gap_q[$];
   hdr_beat_t exp_q[$];
   bit        ready_pattern[READY_LEN];
   int        out_count;

   pkt_join_top pkt_join_top_i (
      .clk        (clk),
      .resetn     (resetn),
      .hdr_in     (hdr_in),
      .hdr_valid  (hdr_valid),
      .hdr_ready  (hdr_ready),
      .pyld_in    (pyld_in),
      .pyld_valid (pyld_valid),
      .pyld_ready (pyld_ready),
      .out        (out),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'({$random(seed)} % (hi - lo + 1));
   endfunction

   // builds one stream word from a byte list with noise in unused lanes.
   function automatic beat_t make_beat(input byte_q_t bytes, input int base);
      beat_t b;
      b.keep = '0;
      for (int j = 0; j < NB; j++) begin
         b.data[8*j +: 8] = (base + j < bytes.size()) ? bytes[base + j] : 8'($random(seed));
         b.keep[j]        = (base + j < bytes.size());
      end
      b.last = (base + NB >= bytes.size());
      return b;
   endfunction

   // ----------------------------------------
   // reference packer
   // ----------------------------------------
   function automatic word_q_t pack_expected(input byte_q_t hdr_bytes, input byte_q_t pyld_bytes,
                                             input meta_t meta, input bit drop);
      word_q_t   words;
      byte_q_t   all_bytes;
      hdr_beat_t w;
      int        n;
      words = {};
      if (drop) return words;
      foreach (hdr_bytes[i]) all_bytes.push_back(hdr_bytes[i]);
      foreach (pyld_bytes[i]) all_bytes.push_back(pyld_bytes[i]);
      n = all_bytes.size();
      for (int base = 0; base < n; base += NB) begin
         w = '0;
         for (int j = 0; j < NB; j++) begin
            if (base + j < n) begin
               w.beat.data[8*j +: 8] = all_bytes[base + j];
               w.beat.keep[j]        = 1'b1;
            end
         end
         w.beat.last = (base + NB >= n);
         w.meta      = meta;
         words.push_back(w);
      end
      return words;
   endfunction

   // a header length of zero makes a drop packet.
   task automatic add_packet(input int hdr_len, input int pyld_len, input int max_gap);
      byte_q_t   hdr_bytes;
      byte_q_t   pyld_bytes;
      word_q_t   words;
      hdr_beat_t hw;
      meta_t     meta;
      meta = meta_t'(16'($random(seed)));
      for (int i = 0; i < hdr_len; i++) begin
         hdr_bytes.push_back(8'($random(seed)));
      end
      for (int i = 0; i < pyld_len; i++) begin
         pyld_bytes.push_back(8'($random(seed)));
      end
      for (int base = 0; base == 0 || base < hdr_len; base += NB) begin
         hw.beat = make_beat(hdr_bytes, base);
         // only the first header word carries the real metadata.
         hw.meta = (base == 0) ? meta : meta_t'(16'($random(seed)));
         hdr_stim_q.push_back(hw);
         hdr_gap_q.push_back(rand_range(0, max_gap));
      end
      for (int base = 0; base < pyld_len; base += NB) begin
         pyld_stim_q.push_back(make_beat(pyld_bytes, base));
         pyld_gap_q.push_back(rand_range(0, max_gap));
      end
      words = pack_expected(hdr_bytes, pyld_bytes, meta, hdr_len == 0);
      foreach (words[i]) exp_q.push_back(words[i]);
   endtask

   // ----------------------------------------
   // input drivers and output checker
   // ----------------------------------------
   task automatic drive_stream(input bit is_hdr);
      hdr_beat_t w;
      int        gap;
      int        waited;
      bit        took;
      while ((is_hdr ? hdr_stim_q.size() : pyld_stim_q.size()) > 0) begin
         w = '0;
         if (is_hdr) begin
            w   = hdr_stim_q.pop_front();
            gap = hdr_gap_q.pop_front();
         end else begin
            w.beat = pyld_stim_q.pop_front();
            gap    = pyld_gap_q.pop_front();
         end
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         if (is_hdr) begin
            hdr_in    = w;
            hdr_valid = 1'b1;
         end else begin
            pyld_in    = w.beat;
            pyld_valid = 1'b1;
         end
         waited = 0;
         do begin
            @(negedge clk);
            took = is_hdr ? hdr_ready : pyld_ready;
            @(posedge clk);
            #1;
            waited++;
            assert (took || waited < TIMEOUT)
               else stop_with_error("an input word was not accepted before the timeout");
         end while (!took);
         if (is_hdr) begin
            hdr_valid = 1'b0;
         end else begin
            pyld_valid = 1'b0;
         end
      end
   endtask

   task automatic check_output(input int total);
      hdr_beat_t got;
      hdr_beat_t want;
      int        cycle;
      int        idle;
      bit        took;
      cycle = 0;
      idle  = 0;
      while (out_count < total) begin
         out_ready = ready_pattern[cycle % READY_LEN];
         cycle++;
         @(negedge clk);
         took = out_valid && out_ready;
         got  = out;
         @(posedge clk);
         #1;
         idle++;
         if (took) begin
            idle = 0;
            want = exp_q.pop_front();
            out_count++;
            for (int j = 0; j < NB; j++) begin
               if (!want.beat.keep[j]) got.beat.data[8*j +: 8] = 8'h00;
            end
            assert (got.beat.keep == want.beat.keep) else stop_with_error($sformatf(
               "FAILED t=%0t out.beat.keep got %h expected %h", $time, got.beat.keep,
               want.beat.keep));
            assert (got.beat.last == want.beat.last) else stop_with_error($sformatf(
               "FAILED t=%0t out.beat.last got %b expected %b", $time, got.beat.last,
               want.beat.last));
            assert (got.beat.data == want.beat.data) else stop_with_error($sformatf(
               "FAILED t=%0t out.beat.data got %h expected %h", $time, got.beat.data,
               want.beat.data));
            assert (got.meta == want.meta) else stop_with_error($sformatf(
               "FAILED t=%0t out.meta got %h expected %h", $time, got.meta, want.meta));
         end
         assert (idle < TIMEOUT) else stop_with_error("no output word arrived before the timeout");
      end
      // no stray words after the last packet.
      out_ready = 1'b1;
      repeat (20) begin
         @(negedge clk);
         assert (!out_valid)
            else stop_with_error("an output word appeared after the last expected packet");
         @(posedge clk);
         #1;
      end
   endtask

   // bound property failures on the top level.
   always @(negedge clk) begin
      assert (pkt_join_top_i.assertions_i.violations == 0)
         else stop_with_error("a bound assertion on the top level failed");
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      int hlen;
      int plen;
      int total;
      seed       = 32'h5c041c64;
      resetn     = 1'b0;
      hdr_in     = '0;
      hdr_valid  = 1'b0;
      pyld_in    = '0;
      pyld_valid = 1'b0;
      out_ready  = 1'b0;
      out_count  = 0;
      for (int i = 0; i < READY_LEN; i++) begin
         ready_pattern[i] = (i < 64) || ({$random(seed)} % 4 != 0);
      end
      // directed shapes cover boundaries, spills and a drop.
      add_packet(3, 20, 0);
      add_packet(16, 10, 0);
      add_packet(13, 9, 0);
      add_packet(6, 5, 0);
      add_packet(8, 8, 0);
      add_packet(12, 15, 0);
      add_packet(0, 11, 0);
      add_packet(5, 3, 0);
      repeat (NUM_RAND) begin
         hlen = ({$random(seed)} % 8 == 0) ? 0 : rand_range(1, 24);
         plen = rand_range(1, 40);
         add_packet(hlen, plen, 3);
      end
      total = exp_q.size();
      repeat (8) @(posedge clk);
      #1;
      resetn = 1'b1;
      fork
         drive_stream(1'b1);
         drive_stream(1'b0);
         check_output(total);
      join
      if (pkt_join_top_i.assertions_i.violations != 0) begin
         stop_with_error("the bound assertions reported violations");
      end else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

/* pkt_join.f */
+incdir+hdl
hdl/join_pkg.sv
hdl/stream_reg.sv
hdl/byte_merge.sv
hdl/join_fsm.sv
hdl/pkt_join_top.sv
tests/pkt_join_sva.sv
tests/pkt_join_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := pkt_join_tb
FILE_LIST := pkt_join.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
PASS_MSG  := TESTBENCH PASSED
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all run clean

all: $(SIM)

# rebuild only when a source or the file list changes
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# the run passes only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
